// ==== include/flight_settings.svh ====
// Pulse and frame constants count us_clk ticks and hold only for a 1 MHz tick
`ifndef FLIGHT_SETTINGS_SVH
`define FLIGHT_SETTINGS_SVH

// Throttle value and controller arithmetic widths
`define REC_VAL_BIT_WIDTH 8
`define OPS_BIT_WIDTH     16

// Throttle limits, in throttle steps
`define THR_IDLE_LEVEL   10
`define THR_MAX_LEVEL    250
`define THR_CHANGE_LIMIT 5

// Knees of the normal and easy scale curves
`define THR_MID_LOW   42
`define THR_MID_HIGH  209
`define THR_EASY_KNEE 35

// Pulse timing in microseconds
`define RC_MIN_PULSE_US   1000
`define PULSE_US_PER_STEP 4
`define ESC_FRAME_TICKS   4000

`endif

// ==== logic/flight_pkg.sv ====
// Types shared by the throttle path and its testbench, sized by flight_settings.svh
`include "flight_settings.svh"

package flight_pkg;

	// Receiver sample, value stays stable between new_frame strobes
	typedef struct packed {
		logic                          new_frame;
		logic [`REC_VAL_BIT_WIDTH-1:0] value;
	} rc_sample_t;

	// Controller status levels
	typedef struct packed {
		logic active;
		logic complete;
	} ctrl_status_t;

	// Mode switch field
	typedef struct packed {
		// Reserved for future modes
		logic [1:0] reserved;
		logic       easy;
	} throttle_mode_t;

endpackage

// ==== logic/rc_pulse_capture.sv ====
// Expects one receiver channel with a pulse shorter than the counter range; long pulses saturate
`timescale 1ns/1ps
`include "flight_settings.svh"

module rc_pulse_capture import flight_pkg::*; (
	input  logic       us_clk,
	input  logic       resetn,
	input  logic       rc_pin,
	output rc_sample_t rc_sample
);

	localparam int RW = `REC_VAL_BIT_WIDTH;
	localparam int MAX_US = `RC_MIN_PULSE_US + ((1 << RW) - 1) * `PULSE_US_PER_STEP;
	localparam int CW = $clog2(MAX_US + 1);

	localparam logic [CW-1:0] MIN_CNT  = CW'(`RC_MIN_PULSE_US);
	localparam logic [CW-1:0] STEP_CNT = CW'(`PULSE_US_PER_STEP);
	localparam logic [CW-1:0] TOP_STEP = CW'((1 << RW) - 1);

	logic [1:0]    pin_sync;
	logic          pin_prev;
	logic          fall;
	logic [CW-1:0] high_cnt;
	logic [CW-1:0] steps;
	logic [RW-1:0] value_next;

	// Two-flop synchronizer plus one stage for edge detection
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			pin_sync <= '0;
			pin_prev <= 1'b0;
		end else begin
			pin_sync <= {pin_sync[0], rc_pin};
			pin_prev <= pin_sync[1];
		end
	end

	assign fall = pin_prev & ~pin_sync[1];

	// High time in ticks, holds at all ones
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			high_cnt <= '0;
		end else if (pin_sync[1]) begin
			if (high_cnt != '1)
				high_cnt <= high_cnt + 1'b1;
		end else begin
			high_cnt <= '0;
		end
	end

	// Width to throttle step
	always_comb begin
		steps = (high_cnt - MIN_CNT) / STEP_CNT;
		if (high_cnt < MIN_CNT)
			value_next = '0;
		else if (steps > TOP_STEP)
			value_next = '1;
		else
			value_next = steps[RW-1:0];
	end

	// New sample one cycle after the synchronized falling edge
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rc_sample <= '0;
		end else begin
			rc_sample.new_frame <= fall;
			if (fall)
				rc_sample.value <= value_next;
		end
	end

endmodule

// ==== logic/throttle_controller.sv ====
// One frame takes six cycles from start; a start seen while busy is held and served once
`timescale 1ns/1ps
`include "flight_settings.svh"

module throttle_controller import flight_pkg::*; (
	input  logic                          us_clk,
	input  logic                          resetn,
	input  rc_sample_t                    rc_sample,
	input  logic                          tc_enable_n,
	input  throttle_mode_t                switch_a,
	input  logic                          imu_ready,
	output logic [`REC_VAL_BIT_WIDTH-1:0] throttle_value,
	output ctrl_status_t                  ctrl_status
);

	localparam int RW = `REC_VAL_BIT_WIDTH;
	localparam int OW = `OPS_BIT_WIDTH;

	localparam logic [6:0]
		ST_INIT          = 7'b0000001,
		ST_WAITING       = 7'b0000010,
		ST_DEGLITCH      = 7'b0000100,
		ST_LINEAR_SCALE  = 7'b0001000,
		ST_CHANGE_LIMIT  = 7'b0010000,
		ST_ASSIGN_OUTPUT = 7'b0100000,
		ST_COMPLETE      = 7'b1000000;

	localparam logic [RW-1:0] IDLE_RV = RW'(`THR_IDLE_LEVEL);
	localparam logic [RW-1:0] MAX_RV  = RW'(`THR_MAX_LEVEL);

	localparam logic [OW-1:0] IDLE_OV      = OW'(`THR_IDLE_LEVEL);
	localparam logic [OW-1:0] MAX_OV       = OW'(`THR_MAX_LEVEL);
	localparam logic [OW-1:0] STEP_OV      = OW'(`THR_CHANGE_LIMIT);
	localparam logic [OW-1:0] MID_LOW_OV   = OW'(`THR_MID_LOW);
	localparam logic [OW-1:0] MID_HIGH_OV  = OW'(`THR_MID_HIGH);
	localparam logic [OW-1:0] EASY_KNEE_OV = OW'(`THR_EASY_KNEE);

	// Curve offsets
	localparam logic [OW-1:0] EASY_OFFSET = OW'(128);
	localparam logic [OW-1:0] MID_OFFSET  = OW'(61);
	localparam logic [OW-1:0] HIGH_OFFSET = OW'(252);

	logic [6:0]    state;
	logic [6:0]    next_state;
	logic          start_flag;
	logic [RW-1:0] clamped_in;
	logic [RW-1:0] latched_throttle;
	logic [RW-1:0] prev_latched;
	logic [RW-1:0] prev_out;
	logic [RW-1:0] limited;
	logic [OW-1:0] debounced;
	logic [OW-1:0] scaled;
	logic [OW-1:0] scale_next;
	logic [OW-1:0] limit_next;
	logic [OW-1:0] up_bound;
	logic [OW-1:0] dn_bound;

	// Start is held until the FSM leaves waiting
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			start_flag <= 1'b0;
		else if (rc_sample.new_frame)
			start_flag <= 1'b1;
		else if (state == ST_WAITING && start_flag)
			start_flag <= 1'b0;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= ST_INIT;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			ST_INIT:          next_state = imu_ready ? ST_WAITING : ST_INIT;
			ST_WAITING:       next_state = start_flag ? ST_DEGLITCH : ST_WAITING;
			ST_DEGLITCH:      next_state = ST_LINEAR_SCALE;
			ST_LINEAR_SCALE:  next_state = ST_CHANGE_LIMIT;
			ST_CHANGE_LIMIT:  next_state = ST_ASSIGN_OUTPUT;
			ST_ASSIGN_OUTPUT: next_state = ST_COMPLETE;
			ST_COMPLETE:      next_state = ST_WAITING;
			default:          next_state = ST_INIT;
		endcase
	end

	// Input clamp, low values mean motor off
	always_comb begin
		if (rc_sample.value < IDLE_RV)
			clamped_in = '0;
		else if (rc_sample.value > MAX_RV)
			clamped_in = MAX_RV;
		else
			clamped_in = rc_sample.value;
	end

	// Piecewise-linear curves
	always_comb begin
		if (switch_a.easy) begin
			if (debounced < EASY_KNEE_OV)
				scale_next = debounced << 2;
			else
				scale_next = (debounced >> 2) + EASY_OFFSET;
		end else begin
			if (debounced < MID_LOW_OV)
				scale_next = debounced << 1;
			else if (debounced > MID_HIGH_OV)
				scale_next = (debounced << 1) - HIGH_OFFSET;
			else
				scale_next = (debounced >> 1) + MID_OFFSET;
		end
	end

	// Rate limit against the last output
	always_comb begin
		up_bound = OW'(prev_out) + STEP_OV;
		dn_bound = OW'(prev_out) - STEP_OV;
		if (scaled < IDLE_OV)
			limit_next = '0;
		else if (scaled > up_bound)
			limit_next = (up_bound > MAX_OV) ? MAX_OV : up_bound;
		else if (OW'(prev_out) > scaled + STEP_OV)
			limit_next = (dn_bound < IDLE_OV) ? '0 : dn_bound;
		else
			limit_next = (scaled > MAX_OV) ? MAX_OV : scaled;
	end

	// Pipeline registers, one stage per state
	always_ff @(posedge us_clk) begin
		case (state)
			ST_WAITING: begin
				if (start_flag)
					latched_throttle <= clamped_in;
			end
			ST_DEGLITCH: begin
				// A single idle frame after a live one repeats the previous value
				if (latched_throttle <= IDLE_RV && prev_latched > IDLE_RV)
					debounced <= OW'(prev_latched);
				else
					debounced <= OW'(latched_throttle);
			end
			ST_LINEAR_SCALE: scaled <= scale_next;
			ST_CHANGE_LIMIT: limited <= limit_next[RW-1:0];
			default: ;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			ctrl_status    <= '0;
			throttle_value <= '0;
			prev_latched   <= '0;
			prev_out       <= '0;
		end else begin
			case (state)
				ST_INIT: begin
					ctrl_status    <= '{active: 1'b0, complete: 1'b1};
					throttle_value <= '0;
				end
				ST_WAITING: ctrl_status <= '0;
				ST_DEGLITCH: begin
					ctrl_status  <= '{active: 1'b1, complete: 1'b0};
					// Raw value is remembered even when it was replaced
					prev_latched <= latched_throttle;
				end
				ST_LINEAR_SCALE, ST_CHANGE_LIMIT: begin
					ctrl_status <= '{active: 1'b1, complete: 1'b0};
				end
				ST_ASSIGN_OUTPUT: begin
					ctrl_status    <= '{active: 1'b1, complete: 1'b0};
					throttle_value <= tc_enable_n ? latched_throttle : limited;
				end
				ST_COMPLETE: begin
					ctrl_status <= '{active: 1'b0, complete: 1'b1};
					prev_out    <= throttle_value;
				end
				default: begin
					ctrl_status    <= '0;
					throttle_value <= '0;
				end
			endcase
		end
	end

endmodule

// ==== logic/esc_pulse_gen.sv ====
// Width changes only at frame boundaries, so a new throttle value waits up to one ESC frame
`timescale 1ns/1ps
`include "flight_settings.svh"

module esc_pulse_gen (
	input  logic                          us_clk,
	input  logic                          resetn,
	input  logic [`REC_VAL_BIT_WIDTH-1:0] throttle_value,
	output logic                          esc_pin
);

	localparam int CW = $clog2(`ESC_FRAME_TICKS);

	localparam logic [CW-1:0] FRAME_LAST = CW'(`ESC_FRAME_TICKS - 1);
	localparam logic [CW-1:0] MIN_WIDTH  = CW'(`RC_MIN_PULSE_US);

	logic [CW-1:0] frame_cnt;
	logic [CW-1:0] width_q;
	logic [CW-1:0] width_next;
	logic          frame_end;

	assign frame_end  = (frame_cnt == FRAME_LAST);
	assign width_next = MIN_WIDTH + CW'(`PULSE_US_PER_STEP * throttle_value);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			frame_cnt <= '0;
			width_q   <= MIN_WIDTH;
			esc_pin   <= 1'b0;
		end else begin
			if (frame_end) begin
				frame_cnt <= '0;
				width_q   <= width_next;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			// Pin lags the counter by one tick, high time is still width_q ticks
			esc_pin <= (frame_cnt < width_q);
		end
	end

endmodule

// ==== logic/flight_throttle_top.sv ====
// Single channel and single motor, switch and enable inputs must already be synchronous to us_clk
`timescale 1ns/1ps
`include "flight_settings.svh"

module flight_throttle_top import flight_pkg::*; (
	input  logic                          us_clk,
	input  logic                          resetn,
	input  logic                          rc_pin,
	input  logic                          imu_ready,
	input  throttle_mode_t                switch_a,
	input  logic                          tc_enable_n,
	output logic [`REC_VAL_BIT_WIDTH-1:0] throttle_value,
	output ctrl_status_t                  ctrl_status,
	output logic                          esc_pin
);

	rc_sample_t rc_sample;

	// Receiver pulse to throttle step
	rc_pulse_capture i_capture (
		.us_clk    (us_clk),
		.resetn    (resetn),
		.rc_pin    (rc_pin),
		.rc_sample (rc_sample)
	);

	throttle_controller i_controller (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.rc_sample      (rc_sample),
		.tc_enable_n    (tc_enable_n),
		.switch_a       (switch_a),
		.imu_ready      (imu_ready),
		.throttle_value (throttle_value),
		.ctrl_status    (ctrl_status)
	);

	// Motor output
	esc_pulse_gen i_esc (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.throttle_value (throttle_value),
		.esc_pin        (esc_pin)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
// Free-running 10 ns clock standing in for the 1 us tick; reset is low for the first 8 edges
`timescale 1ns/1ps

module tb_clock_gen (
	output logic us_clk,
	output logic resetn
);

	initial begin
		us_clk = 1'b0;
		forever #5 us_clk = ~us_clk;
	end

	// Release shortly after the eighth rising edge
	initial begin
		resetn = 1'b0;
		repeat (8) @(posedge us_clk);
		#1 resetn = 1'b1;
	end

endmodule

// ==== dv/flight_throttle_tb.sv ====
// Directed tests of the throttle path; inputs change 1 ns after us_clk rises, outputs sampled then
`timescale 1ns/1ps
`include "flight_settings.svh"

module flight_throttle_tb
	import flight_pkg::*;
();

	localparam int FRAME_TICKS      = `ESC_FRAME_TICKS;
	localparam int COMPLETE_TIMEOUT = 64;

	logic                          us_clk;
	logic                          resetn;
	logic                          rc_pin;
	logic                          imu_ready;
	logic                          tc_enable_n;
	logic                          esc_pin;
	throttle_mode_t                switch_a;
	logic [`REC_VAL_BIT_WIDTH-1:0] throttle_value;
	ctrl_status_t                  ctrl_status;

	integer seed;
	// Reference model history
	int     m_prev_latched;
	int     m_prev_out;

	tb_clock_gen i_clock (
		.us_clk (us_clk),
		.resetn (resetn)
	);

	flight_throttle_top i_dut (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.rc_pin         (rc_pin),
		.imu_ready      (imu_ready),
		.switch_a       (switch_a),
		.tc_enable_n    (tc_enable_n),
		.throttle_value (throttle_value),
		.ctrl_status    (ctrl_status),
		.esc_pin        (esc_pin)
	);

	task automatic next_cycle();
		@(posedge us_clk);
		#1;
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string test_name, input int expected, input int actual);
		assert (actual == expected) else begin
			fail_run($sformatf("Mismatch in %s: expected %0d, actual %0d",
				test_name, expected, actual));
		end
	endtask

	function automatic int clamp_input(input int v);
		if (v < `THR_IDLE_LEVEL)
			return 0;
		if (v > `THR_MAX_LEVEL)
			return `THR_MAX_LEVEL;
		return v;
	endfunction

	function automatic int scale_curve(input int v, input bit easy);
		if (easy)
			return (v < `THR_EASY_KNEE) ? v * 4 : v / 4 + 128;
		if (v < `THR_MID_LOW)
			return v * 2;
		if (v > `THR_MID_HIGH)
			return v * 2 - 252;
		return v / 2 + 61;
	endfunction

	// Ramp up to the ceiling, ramp down with a cut to zero near idle
	function automatic int limit_change(input int target, input int last);
		int r;
		if (target < `THR_IDLE_LEVEL)
			return 0;
		if (target > last + `THR_CHANGE_LIMIT) begin
			r = last + `THR_CHANGE_LIMIT;
			return (r > `THR_MAX_LEVEL) ? `THR_MAX_LEVEL : r;
		end
		if (target < last - `THR_CHANGE_LIMIT) begin
			r = last - `THR_CHANGE_LIMIT;
			return (r < `THR_IDLE_LEVEL) ? 0 : r;
		end
		return (target > `THR_MAX_LEVEL) ? `THR_MAX_LEVEL : target;
	endfunction

	task automatic model_frame(input int raw, output int expected);
		int latched;
		int used;
		latched = clamp_input(raw);
		// One idle frame after a live one repeats the previous value
		if (latched <= `THR_IDLE_LEVEL && m_prev_latched > `THR_IDLE_LEVEL)
			used = m_prev_latched;
		else
			used = latched;
		m_prev_latched = latched;
		if (tc_enable_n)
			expected = latched;
		else
			expected = limit_change(scale_curve(used, switch_a.easy), m_prev_out);
		m_prev_out = expected;
	endtask

	task automatic send_rc_pulse(input int value);
		rc_pin = 1'b1;
		repeat (`RC_MIN_PULSE_US + `PULSE_US_PER_STEP * value) next_cycle();
		rc_pin = 1'b0;
	endtask

	task automatic wait_complete(input string test_name);
		int n;
		n = 0;
		while (!ctrl_status.complete && n < COMPLETE_TIMEOUT) begin
			next_cycle();
			n++;
		end
		assert (ctrl_status.complete) else begin
			fail_run($sformatf("%s: complete never rose after the receiver pulse", test_name));
		end
	endtask

	task automatic run_frame(input string test_name, input int raw, output int expected);
		send_rc_pulse(raw);
		wait_complete(test_name);
		model_frame(raw, expected);
		check_value(test_name, expected, int'(throttle_value));
	endtask

	// High time of the next full ESC pulse, in ticks
	task automatic measure_esc_high(output int ticks);
		int n;
		n = 0;
		while (esc_pin && n < 2 * FRAME_TICKS) begin
			next_cycle();
			n++;
		end
		assert (!esc_pin) else fail_run("ESC pin never went low");
		n = 0;
		while (!esc_pin && n < 2 * FRAME_TICKS) begin
			next_cycle();
			n++;
		end
		assert (esc_pin) else fail_run("ESC pin never started a pulse");
		ticks = 0;
		while (esc_pin && ticks <= FRAME_TICKS) begin
			next_cycle();
			ticks++;
		end
		assert (!esc_pin) else fail_run("ESC pin stayed high for a whole frame");
	endtask

	task automatic test_reset_init();
		int n;
		int width;
		int out;
		next_cycle();
		n = 0;
		while (!resetn && n < 20) begin
			next_cycle();
			n++;
		end
		assert (resetn) else fail_run("Reset was never released");
		next_cycle();
		// Held in init while the IMU is not ready
		repeat (20) begin
			next_cycle();
			check_value("reset_init complete", 1, int'(ctrl_status.complete));
			check_value("reset_init active", 0, int'(ctrl_status.active));
			check_value("reset_init throttle", 0, int'(throttle_value));
		end
		measure_esc_high(width);
		check_value("reset_init esc width", `RC_MIN_PULSE_US, width);
		imu_ready = 1'b1;
		n = 0;
		while (ctrl_status.complete && n < 8) begin
			next_cycle();
			n++;
		end
		assert (!ctrl_status.complete) else begin
			fail_run("reset_init: complete stayed high after imu_ready rose");
		end
		run_frame("reset_init", 0, out);
		check_value("reset_init active at complete", 0, int'(ctrl_status.active));
		next_cycle();
		check_value("reset_init complete pulse", 0, int'(ctrl_status.complete));
	endtask

	task automatic test_normal_scale();
		int fixed_vals[4] = '{255, 251, 5, 230};
		int v;
		int out;
		switch_a    = '0;
		tc_enable_n = 1'b0;
		repeat (24) begin
			v = $random(seed) & 32'hff;
			run_frame("normal_scale", v, out);
		end
		foreach (fixed_vals[i])
			run_frame("normal_scale", fixed_vals[i], out);
	endtask

	task automatic test_easy_mode();
		int fixed_vals[6] = '{20, 34, 35, 200, 9, 120};
		int v;
		int out;
		switch_a.easy = 1'b1;
		foreach (fixed_vals[i])
			run_frame("easy_mode", fixed_vals[i], out);
		repeat (16) begin
			v = $random(seed) & 32'hff;
			run_frame("easy_mode", v, out);
		end
		switch_a.easy = 1'b0;
	endtask

	task automatic test_bypass();
		int vals[8] = '{5, 255, 100, 0, 251, 10, 250, 9};
		int out;
		tc_enable_n = 1'b1;
		foreach (vals[i])
			run_frame("bypass", vals[i], out);
		tc_enable_n = 1'b0;
	endtask

	task automatic test_deglitch();
		int n;
		int out;
		int held;
		int target;
		target = scale_curve(150, 1'b0);
		out    = -1;
		n      = 0;
		while (out != target && n < 60) begin
			run_frame("deglitch", 150, out);
			n++;
		end
		assert (out == target) else fail_run("deglitch: output never settled for input 150");
		held = target;
		run_frame("deglitch", `THR_IDLE_LEVEL, out);
		check_value("deglitch hold", held, int'(throttle_value));
		repeat (3) begin
			run_frame("deglitch", `THR_IDLE_LEVEL, out);
			held = held - `THR_CHANGE_LIMIT;
			check_value("deglitch ramp", held, int'(throttle_value));
		end
	endtask

	task automatic test_esc_pulse();
		int width;
		repeat (2) begin
			measure_esc_high(width);
			check_value("esc_pulse",
				`RC_MIN_PULSE_US + `PULSE_US_PER_STEP * m_prev_out, width);
		end
	endtask

	initial begin
		rc_pin         = 1'b0;
		imu_ready      = 1'b0;
		switch_a       = '0;
		tc_enable_n    = 1'b0;
		seed           = 32'he756_e98b;
		m_prev_latched = 0;
		m_prev_out     = 0;

		test_reset_init();
		test_normal_scale();
		test_easy_mode();
		test_bypass();
		test_deglitch();
		test_esc_pulse();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
logic/flight_pkg.sv
logic/rc_pulse_capture.sv
logic/throttle_controller.sv
logic/esc_pulse_gen.sv
logic/flight_throttle_top.sv
dv/tb_clock_gen.sv
dv/flight_throttle_tb.sv

// ==== Makefile ====
# Verilator build and run of the throttle path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := flight_throttle_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
